// File: logic/dma_wr_pkg.sv
package dma_wr_pkg;

  ////////////////////////////////////////////////////////////
  // Data path geometry
  ////////////////////////////////////////////////////////////

  // Width of one memory and stream word, in bytes
  localparam int BYTES_PER_WORD = 8;

  // Address bits that pick a byte inside a word
  localparam int OFS_BITS = 3;

  ////////////////////////////////////////////////////////////
  // Typed vectors
  ////////////////////////////////////////////////////////////

  // One stream beat or memory word
  typedef logic [8*BYTES_PER_WORD-1:0] word_t;

  // Byte enables of a word, one bit per byte lane
  typedef logic [BYTES_PER_WORD-1:0] keep_t;

  // Byte address into the packet memory
  typedef logic [15:0] addr_t;

  // Packet length in bytes, as reported in the descriptor
  typedef logic [15:0] len_t;

  // Shift between the aligned word and the packet start
  // One extra bit, since an aligned base gives a full word of shift
  typedef logic [OFS_BITS:0] ofs_t;

  // Number of set bits in one keep_t, which can reach BYTES_PER_WORD
  typedef logic [OFS_BITS:0] byte_cnt_t;

  // Write side only tracks whether a packet is in flight
  typedef enum logic {
    wr_idle,
    wr_busy
  } wr_state_t;

endpackage

// File: logic/wr_capture.sv
`timescale 1ns/1ps

module wr_capture import dma_wr_pkg::*; #(
  parameter int DEST_WIDTH = 8,
  parameter int USER_WIDTH = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  word_t                 s_axis_tdata,
  input  keep_t                 s_axis_tkeep,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,
  input  logic [DEST_WIDTH-1:0] s_axis_tdest,
  input  logic [USER_WIDTH-1:0] s_axis_tuser,
  input  addr_t                 wr_base_addr,
  input  logic                  wr_taken,
  input  logic                  desc_block,
  output word_t                 cap_data_1,
  output keep_t                 cap_strb_1,
  output logic                  cap_en,
  output logic                  cap_first,
  output logic                  cap_last_word,
  output logic                  cap_advance,
  output addr_t                 cap_start_addr,
  output ofs_t                  cap_offset,
  output logic [DEST_WIDTH-1:0] meta_dest,
  output logic [USER_WIDTH-1:0] meta_user
);

  wr_state_t wr_state;
  wr_state_t wr_state_next;
  logic      beat;
  logic      latch_info;
  logic      wr_last;
  logic      strb_left;
  logic      extra_cycle;
  logic      extra_cycle_r;
  ofs_t      new_offset;

  ////////////////////////////////////////////////////////////
  // Handshake and packet boundaries
  ////////////////////////////////////////////////////////////

  assign beat        = s_axis_tvalid && s_axis_tready;
  assign cap_advance = cap_en && wr_taken;

  // The tail of the last beat spills into one more word
  assign extra_cycle = wr_last && strb_left;

  // Last word is the last beat itself, or the extra word behind it
  assign cap_last_word = cap_en && ((wr_last && !extra_cycle) || extra_cycle_r);

  // Stall while the memory is busy or the extra word is due
  // A blocked descriptor only stops the closing beat of a packet
  assign s_axis_tready = wr_taken && !extra_cycle && !(s_axis_tlast && desc_block);

  // A new packet starts when idle, or right as the previous one drains
  assign latch_info = ((wr_state == wr_idle) || (cap_last_word && wr_taken)) && beat;

  // Shift that moves the first beat up to the base address byte
  assign new_offset = ofs_t'(BYTES_PER_WORD) - {1'b0, wr_base_addr[OFS_BITS-1:0]};

  always_comb begin
    wr_state_next = wr_state;
    if ((wr_state == wr_idle) && beat) begin
      wr_state_next = wr_busy;
    end else if ((wr_state == wr_busy) && cap_last_word && wr_taken && !beat) begin
      wr_state_next = wr_idle;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      wr_state <= wr_idle;
    end else begin
      wr_state <= wr_state_next;
    end
  end

  ////////////////////////////////////////////////////////////
  // Per-packet metadata and first pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (latch_info) begin
      cap_start_addr <= wr_base_addr;
      cap_offset     <= new_offset;
      meta_dest      <= s_axis_tdest;
      meta_user      <= s_axis_tuser;
    end
    if (beat) begin
      cap_data_1 <= s_axis_tdata;
    end
  end

  // When the extra word goes out the first stage is emptied
  // so that only the spilled tail of stage two is written
  // The spill flag is worked out one beat early to keep the
  // tready path short
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_strb_1 <= '0;
      wr_last    <= 1'b0;
      strb_left  <= 1'b0;
    end else if (extra_cycle && cap_advance) begin
      cap_strb_1 <= '0;
      wr_last    <= 1'b0;
      strb_left  <= 1'b0;
    end else if (beat) begin
      cap_strb_1 <= s_axis_tkeep;
      wr_last    <= s_axis_tlast;
      if (latch_info) begin
        strb_left <= |(s_axis_tkeep >> new_offset);
      end else begin
        strb_left <= |(s_axis_tkeep >> cap_offset);
      end
    end
  end

  // Write pending after a beat, after the extra word is queued,
  // or while the memory holds off the current one
  always_ff @(posedge clk) begin
    if (rst) begin
      cap_en        <= 1'b0;
      cap_first     <= 1'b0;
      extra_cycle_r <= 1'b0;
    end else begin
      cap_en    <= beat || (cap_advance && extra_cycle) || (cap_en && !wr_taken);
      cap_first <= latch_info || (cap_first && !wr_taken);
      if (cap_advance) begin
        extra_cycle_r <= extra_cycle;
      end
    end
  end

endmodule

// File: logic/wr_align.sv
`timescale 1ns/1ps

module wr_align import dma_wr_pkg::*; (
  input  logic  clk,
  input  logic  rst,
  input  word_t cap_data_1,
  input  keep_t cap_strb_1,
  input  logic  cap_en,
  input  logic  cap_first,
  input  logic  cap_last_word,
  input  addr_t cap_start_addr,
  input  ofs_t  cap_offset,
  input  logic  mem_wr_ready,
  output logic  mem_wr_en,
  output addr_t mem_wr_addr,
  output word_t mem_wr_data,
  output keep_t mem_wr_strb,
  output logic  mem_wr_last,
  output logic  wr_taken,
  output keep_t align_strb
);

  word_t data_2;
  keep_t strb_2;
  addr_t next_addr;
  addr_t aligned_addr;
  logic  advance;

  // Current write leaves this clock
  assign advance = cap_en && mem_wr_ready;

  ////////////////////////////////////////////////////////////
  // Second pipeline register
  ////////////////////////////////////////////////////////////

  always_ff @(posedge clk) begin
    if (advance) begin
      data_2 <= cap_data_1;
    end
  end

  // Strobe is zeroed once a packet is done, so the first write
  // of the next packet picks up nothing from the old one
  always_ff @(posedge clk) begin
    if (rst) begin
      strb_2 <= '0;
    end else if (cap_last_word && mem_wr_ready) begin
      strb_2 <= '0;
    end else if (advance) begin
      strb_2 <= cap_strb_1;
    end
  end

  ////////////////////////////////////////////////////////////
  // Byte shift across the two stages
  ////////////////////////////////////////////////////////////

  // Older beat supplies the low lanes, newer beat the high ones
  // A shift of a full word leaves the newer beat untouched
  assign mem_wr_data = word_t'({cap_data_1, data_2} >> {cap_offset, 3'd0});
  assign mem_wr_strb = keep_t'({cap_strb_1, strb_2} >> cap_offset);

  ////////////////////////////////////////////////////////////
  // Write address
  ////////////////////////////////////////////////////////////

  // Word containing the base address
  assign aligned_addr = cap_start_addr & ~addr_t'(BYTES_PER_WORD - 1);

  always_ff @(posedge clk) begin
    if (advance) begin
      next_addr <= mem_wr_addr + addr_t'(BYTES_PER_WORD);
    end
  end

  assign mem_wr_addr = cap_first ? aligned_addr : next_addr;

  // Port outputs, the shifted strobe also feeds the byte counter
  assign mem_wr_en   = cap_en;
  assign mem_wr_last = cap_last_word;
  assign wr_taken    = mem_wr_ready;
  assign align_strb  = mem_wr_strb;

endmodule

// File: logic/wr_len_count.sv
`timescale 1ns/1ps

module wr_len_count import dma_wr_pkg::*; #(
  parameter int DEST_WIDTH = 8,
  parameter int USER_WIDTH = 2
) (
  input  logic                  clk,
  input  logic                  rst,
  input  keep_t                 align_strb,
  input  logic                  cap_first,
  input  logic                  cap_last_word,
  input  logic                  cap_advance,
  input  addr_t                 cap_start_addr,
  input  logic [DEST_WIDTH-1:0] meta_dest,
  input  logic [USER_WIDTH-1:0] meta_user,
  input  logic                  recv_desc_ready,
  output logic                  recv_desc_valid,
  output addr_t                 recv_desc_addr,
  output len_t                  recv_desc_len,
  output logic [DEST_WIDTH-1:0] recv_desc_tdest,
  output logic [USER_WIDTH-1:0] recv_desc_tuser,
  output logic                  desc_block
);

  byte_cnt_t             one_count;
  len_t                  len_cnt;
  len_t                  next_len;
  logic                  late_write;
  logic                  direct_load;
  logic                  hold_load;
  logic                  late_load;
  addr_t                 pend_addr;
  len_t                  pend_len;
  logic [DEST_WIDTH-1:0] pend_dest;
  logic [USER_WIDTH-1:0] pend_user;

  ////////////////////////////////////////////////////////////
  // Byte count
  ////////////////////////////////////////////////////////////

  // Zero lanes can sit anywhere in the strobe, so count every bit
  always_comb begin
    one_count = '0;
    for (int i = 0; i < BYTES_PER_WORD; i++) begin
      one_count = one_count + byte_cnt_t'(align_strb[i]);
    end
  end

  assign next_len = cap_first ? len_t'(one_count) : len_cnt + len_t'(one_count);

  always_ff @(posedge clk) begin
    if (rst) begin
      len_cnt <= '0;
    end else if (cap_advance) begin
      len_cnt <= next_len;
    end
  end

  ////////////////////////////////////////////////////////////
  // Descriptor output
  ////////////////////////////////////////////////////////////

  assign desc_block  = recv_desc_valid && !recv_desc_ready;
  assign direct_load = cap_last_word && cap_advance && !desc_block;
  assign hold_load   = cap_last_word && cap_advance && desc_block;
  assign late_load   = late_write && recv_desc_ready;

  // Metadata still belongs to this packet on its final write,
  // so a blocked descriptor is parked here until the port frees
  always_ff @(posedge clk) begin
    if (hold_load) begin
      pend_addr <= cap_start_addr;
      pend_len  <= next_len;
      pend_dest <= meta_dest;
      pend_user <= meta_user;
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      late_write <= 1'b0;
    end else if (hold_load) begin
      late_write <= 1'b1;
    end else if (recv_desc_ready) begin
      late_write <= 1'b0;
    end
  end

  always_ff @(posedge clk) begin
    if (late_load) begin
      recv_desc_addr  <= pend_addr;
      recv_desc_len   <= pend_len;
      recv_desc_tdest <= pend_dest;
      recv_desc_tuser <= pend_user;
    end else if (direct_load) begin
      recv_desc_addr  <= cap_start_addr;
      recv_desc_len   <= next_len;
      recv_desc_tdest <= meta_dest;
      recv_desc_tuser <= meta_user;
    end
  end

  // Valid stays up across a back-to-back reload
  always_ff @(posedge clk) begin
    if (rst) begin
      recv_desc_valid <= 1'b0;
    end else if (late_load || direct_load) begin
      recv_desc_valid <= 1'b1;
    end else if (recv_desc_ready) begin
      recv_desc_valid <= 1'b0;
    end
  end

endmodule

// File: logic/axis_wr_dma.sv
`timescale 1ns/1ps

module axis_wr_dma import dma_wr_pkg::*; #(
  parameter int DEST_WIDTH = 8,
  parameter int USER_WIDTH = 2
) (
  input  logic                  clk,
  input  logic                  rst,

  // AXI-Stream packet input
  input  word_t                 s_axis_tdata,
  input  keep_t                 s_axis_tkeep,
  input  logic                  s_axis_tvalid,
  output logic                  s_axis_tready,
  input  logic                  s_axis_tlast,
  input  logic [DEST_WIDTH-1:0] s_axis_tdest,
  input  logic [USER_WIDTH-1:0] s_axis_tuser,
  input  addr_t                 wr_base_addr,

  // Memory write port
  output logic                  mem_wr_en,
  output addr_t                 mem_wr_addr,
  output word_t                 mem_wr_data,
  output keep_t                 mem_wr_strb,
  output logic                  mem_wr_last,
  input  logic                  mem_wr_ready,

  // Receive descriptor
  output logic                  recv_desc_valid,
  input  logic                  recv_desc_ready,
  output addr_t                 recv_desc_addr,
  output len_t                  recv_desc_len,
  output logic [DEST_WIDTH-1:0] recv_desc_tdest,
  output logic [USER_WIDTH-1:0] recv_desc_tuser
);

  // Capture stage outputs
  word_t                 cap_data_1;
  keep_t                 cap_strb_1;
  logic                  cap_en;
  logic                  cap_first;
  logic                  cap_last_word;
  logic                  cap_advance;
  addr_t                 cap_start_addr;
  ofs_t                  cap_offset;
  logic [DEST_WIDTH-1:0] meta_dest;
  logic [USER_WIDTH-1:0] meta_user;

  // Feedback paths from the later stages
  logic                  wr_taken;
  keep_t                 align_strb;
  logic                  desc_block;

  ////////////////////////////////////////////////////////////
  // Pipeline stages
  ////////////////////////////////////////////////////////////

  wr_capture #(
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) u_capture (
    .clk, .rst,
    .s_axis_tdata, .s_axis_tkeep, .s_axis_tvalid, .s_axis_tready,
    .s_axis_tlast, .s_axis_tdest, .s_axis_tuser, .wr_base_addr,
    .wr_taken, .desc_block,
    .cap_data_1, .cap_strb_1, .cap_en, .cap_first, .cap_last_word,
    .cap_advance, .cap_start_addr, .cap_offset, .meta_dest, .meta_user
  );

  wr_align u_align (
    .clk, .rst,
    .cap_data_1, .cap_strb_1, .cap_en, .cap_first, .cap_last_word,
    .cap_start_addr, .cap_offset, .mem_wr_ready,
    .mem_wr_en, .mem_wr_addr, .mem_wr_data, .mem_wr_strb, .mem_wr_last,
    .wr_taken, .align_strb
  );

  // Descriptor stage only carries the sideband, never computes on it
  wr_len_count #(
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) u_len_count (
    .clk, .rst,
    .align_strb, .cap_first, .cap_last_word, .cap_advance,
    .cap_start_addr, .meta_dest, .meta_user, .recv_desc_ready,
    .recv_desc_valid, .recv_desc_addr, .recv_desc_len,
    .recv_desc_tdest, .recv_desc_tuser, .desc_block
  );

endmodule

// File: tests/axis_wr_dma_sva.sv
`timescale 1ns/1ps

module axis_wr_dma_sva import dma_wr_pkg::*; #(
  parameter int DEST_WIDTH = 8,
  parameter int USER_WIDTH = 2
) (
  input logic                  clk,
  input logic                  rst,
  input logic                  s_axis_tready,
  input logic                  s_axis_tlast,
  input logic                  mem_wr_en,
  input addr_t                 mem_wr_addr,
  input word_t                 mem_wr_data,
  input keep_t                 mem_wr_strb,
  input logic                  mem_wr_last,
  input logic                  mem_wr_ready,
  input logic                  recv_desc_valid,
  input logic                  recv_desc_ready,
  input addr_t                 recv_desc_addr,
  input len_t                  recv_desc_len,
  input logic [DEST_WIDTH-1:0] recv_desc_tdest,
  input logic [USER_WIDTH-1:0] recv_desc_tuser
);

  int   fail_count = 0;
  logic desc_blocked;

  // Descriptor shown but not yet taken by the consumer
  assign desc_blocked = recv_desc_valid && !recv_desc_ready;

  ////////////////////////////////////////////////////////////
  // Reset and write port
  ////////////////////////////////////////////////////////////

  a_reset_quiet: assert property (@(posedge clk) rst |=> (!mem_wr_en && !recv_desc_valid))
  else begin
    $error("Write enable or descriptor valid high after reset");
    fail_count++;
  end

  a_write_hold: assert property (@(posedge clk) disable iff (rst)
    (mem_wr_en && !mem_wr_ready) |=> (mem_wr_en && $stable(mem_wr_addr) &&
      $stable(mem_wr_data) && $stable(mem_wr_strb) && $stable(mem_wr_last)))
  else begin
    $error("Write port changed while the memory held it off");
    fail_count++;
  end

  // A taken write that still stalls the stream, with no blocked
  // descriptor behind it, is the last beat with a spilled tail
  a_extra_write: assert property (@(posedge clk) disable iff (rst)
    (mem_wr_en && mem_wr_ready && !mem_wr_last && !s_axis_tready &&
     !(s_axis_tlast && desc_blocked)) |=> (mem_wr_en && mem_wr_last))
  else begin
    $error("Spilled tail was not followed by one closing write");
    fail_count++;
  end

  ////////////////////////////////////////////////////////////
  // Descriptor port
  ////////////////////////////////////////////////////////////

  a_desc_hold: assert property (@(posedge clk) disable iff (rst)
    desc_blocked |=> (recv_desc_valid && $stable(recv_desc_addr) && $stable(recv_desc_len) &&
      $stable(recv_desc_tdest) && $stable(recv_desc_tuser)))
  else begin
    $error("Descriptor changed before it was accepted");
    fail_count++;
  end

  a_last_blocked: assert property (@(posedge clk) disable iff (rst)
    (desc_blocked && s_axis_tlast) |-> !s_axis_tready)
  else begin
    $error("Last beat accepted while a descriptor was blocked");
    fail_count++;
  end

endmodule

// File: tests/tb_axis_wr_dma.sv
`timescale 1ns/1ps

module tb_axis_wr_dma import dma_wr_pkg::*; ();

  localparam int DEST_WIDTH = 8;
  localparam int USER_WIDTH = 2;
  localparam int unsigned LCG_SEED = 77166;

  logic                  clk;
  logic                  rst;
  word_t                 s_axis_tdata;
  keep_t                 s_axis_tkeep;
  logic                  s_axis_tvalid;
  logic                  s_axis_tready;
  logic                  s_axis_tlast;
  logic [DEST_WIDTH-1:0] s_axis_tdest;
  logic [USER_WIDTH-1:0] s_axis_tuser;
  addr_t                 wr_base_addr;
  logic                  mem_wr_en;
  addr_t                 mem_wr_addr;
  word_t                 mem_wr_data;
  keep_t                 mem_wr_strb;
  logic                  mem_wr_last;
  logic                  mem_wr_ready;
  logic                  recv_desc_valid;
  logic                  recv_desc_ready;
  addr_t                 recv_desc_addr;
  len_t                  recv_desc_len;
  logic [DEST_WIDTH-1:0] recv_desc_tdest;
  logic [USER_WIDTH-1:0] recv_desc_tuser;

  // Memory seen by the DUT and memory as it should end up
  logic [7:0]            mem [addr_t];
  logic [7:0]            shadow [addr_t];

  // Expected descriptors and write counts, in packet order
  addr_t                 exp_addr [$];
  len_t                  exp_len [$];
  logic [DEST_WIDTH-1:0] exp_dest [$];
  logic [USER_WIDTH-1:0] exp_user [$];
  int                    exp_words [$];
  addr_t                 pkt_base [$];
  int                    pkt_len [$];

  int          desc_seen = 0;
  int          pkts_written = 0;
  int          words_cur = 0;
  int          mon_errors = 0;
  int          chk_errors = 0;
  int          beats_sent = 0;
  int          tests_run = 0;
  int          tests_failed = 0;
  int          test_err_base = 0;
  string       cur_test = "reset";
  logic        ready_random;
  int unsigned pay_state;
  int unsigned gap_state;

  axis_wr_dma #(
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) dut (.*);

  bind axis_wr_dma axis_wr_dma_sva #(
    .DEST_WIDTH (DEST_WIDTH),
    .USER_WIDTH (USER_WIDTH)
  ) sva (
    .clk (clk), .rst (rst), .s_axis_tready (s_axis_tready), .s_axis_tlast (s_axis_tlast),
    .mem_wr_en (mem_wr_en), .mem_wr_addr (mem_wr_addr), .mem_wr_data (mem_wr_data),
    .mem_wr_strb (mem_wr_strb), .mem_wr_last (mem_wr_last), .mem_wr_ready (mem_wr_ready),
    .recv_desc_valid (recv_desc_valid), .recv_desc_ready (recv_desc_ready),
    .recv_desc_addr (recv_desc_addr), .recv_desc_len (recv_desc_len),
    .recv_desc_tdest (recv_desc_tdest), .recv_desc_tuser (recv_desc_tuser)
  );

  ////////////////////////////////////////////////////////////
  // Helpers
  ////////////////////////////////////////////////////////////

  function automatic int unsigned lcg_next(inout int unsigned state);
    state = state * 32'd1103515245 + 32'd12345;
    return state >> 16;
  endfunction

  // Untouched memory reads back a pattern of the full address
  function automatic logic [7:0] fill_byte(input addr_t a);
    return a[7:0] ^ a[15:8] ^ 8'h5a;
  endfunction

  function automatic bit values_match(input string what, input int unsigned exp,
                                      input int unsigned act);
    assert (exp == act) else
      $display("** Error %s: %s expected 0x%0h actual 0x%0h", cur_test, what, exp, act);
    return exp == act;
  endfunction

  function automatic int total_errors();
    return chk_errors + mon_errors + dut.sva.fail_count;
  endfunction

  // Inputs move 2 ns after the rising edge
  task automatic step_cycle();
    @(posedge clk);
    #2;
  endtask

  ////////////////////////////////////////////////////////////
  // Clock, ready gaps and watchdog
  ////////////////////////////////////////////////////////////

  initial begin
    clk = 1'b0;
    forever #10 clk = ~clk;
  end

  // Memory accepts three writes out of four in random mode
  initial begin
    gap_state = LCG_SEED;
    mem_wr_ready = 1'b1;
    forever begin
      step_cycle();
      if (ready_random) mem_wr_ready = (lcg_next(gap_state) % 4) != 0;
      else mem_wr_ready = 1'b1;
    end
  end

  // Budget grows by 20 cycles for every beat put on the stream
  initial begin
    int cycles;
    cycles = 0;
    while (cycles <= 20 * beats_sent + 200) begin
      @(posedge clk);
      cycles++;
    end
    $display("Watchdog expired after %0d cycles in test %s", cycles, cur_test);
    $display("Something failed");
    $finish;
  end

  ////////////////////////////////////////////////////////////
  // Memory model and descriptor checker
  ////////////////////////////////////////////////////////////

  // Sampled at the falling edge, where every port is settled
  always @(negedge clk) begin
    int k;
    if (!rst && mem_wr_en && mem_wr_ready) begin
      for (k = 0; k < BYTES_PER_WORD; k++) begin
        if (mem_wr_strb[k]) mem[mem_wr_addr + addr_t'(k)] = mem_wr_data[k*8 +: 8];
      end
      words_cur++;
      if (mem_wr_last) begin
        if (pkts_written >= exp_words.size()) begin
          $display("Write port closed a packet that was never sent");
          mon_errors++;
        end else if (!values_match("write count", exp_words[pkts_written], words_cur)) begin
          mon_errors++;
        end
        pkts_written++;
        words_cur = 0;
      end
    end
    if (!rst && recv_desc_valid && recv_desc_ready) begin
      if (desc_seen >= exp_addr.size()) begin
        $display("Descriptor delivered with no packet left to describe");
        mon_errors++;
      end else begin
        if (!values_match("desc addr", 32'(exp_addr[desc_seen]), 32'(recv_desc_addr)))
          mon_errors++;
        if (!values_match("desc len", 32'(exp_len[desc_seen]), 32'(recv_desc_len)))
          mon_errors++;
        if (!values_match("desc tdest", 32'(exp_dest[desc_seen]), 32'(recv_desc_tdest)))
          mon_errors++;
        if (!values_match("desc tuser", 32'(exp_user[desc_seen]), 32'(recv_desc_tuser)))
          mon_errors++;
      end
      desc_seen++;
    end
  end

  ////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////

  // Bytes fill lanes from lane 0, so only the last beat can be partial
  task automatic send_packet(input addr_t base, input int len,
                             input logic [DEST_WIDTH-1:0] dest,
                             input logic [USER_WIDTH-1:0] user);
    int    nbeats;
    int    b;
    int    k;
    int    idx;
    logic  accepted;
    word_t data;
    keep_t keep;
    nbeats = (len + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
    exp_addr.push_back(base);
    exp_len.push_back(len_t'(len));
    exp_dest.push_back(dest);
    exp_user.push_back(user);
    exp_words.push_back((int'(base[OFS_BITS-1:0]) + len + BYTES_PER_WORD - 1) / BYTES_PER_WORD);
    pkt_base.push_back(base);
    pkt_len.push_back(len);
    for (b = 0; b < nbeats; b++) begin
      data = '0;
      keep = '0;
      for (k = 0; k < BYTES_PER_WORD; k++) begin
        idx = b * BYTES_PER_WORD + k;
        if (idx < len) begin
          data[k*8 +: 8] = 8'(lcg_next(pay_state));
          keep[k] = 1'b1;
          shadow[base + addr_t'(idx)] = data[k*8 +: 8];
        end
      end
      s_axis_tdata = data;
      s_axis_tkeep = keep;
      s_axis_tlast = (b == nbeats - 1);
      s_axis_tdest = dest;
      s_axis_tuser = user;
      wr_base_addr = base;
      s_axis_tvalid = 1'b1;
      beats_sent++;
      accepted = 1'b0;
      while (!accepted) begin
        @(negedge clk);
        accepted = s_axis_tready;
        step_cycle();
      end
    end
  endtask

  // Every byte of the words a packet touches, and one byte to
  // either side of them, must hold the packet or keep the fill
  task automatic check_region(input addr_t lo, input int count);
    int         i;
    addr_t      a;
    logic [7:0] want;
    logic [7:0] got;
    for (i = 0; i < count; i++) begin
      a = lo + addr_t'(i);
      want = shadow.exists(a) ? shadow[a] : fill_byte(a);
      got = mem.exists(a) ? mem[a] : fill_byte(a);
      if (!values_match($sformatf("byte at 0x%04h", a), 32'(want), 32'(got))) chk_errors++;
    end
  endtask

  task automatic start_test(input string name);
    cur_test = name;
    test_err_base = total_errors();
    pkt_base.delete();
    pkt_len.delete();
  endtask

  task automatic end_test();
    int    p;
    int    errs;
    int    words;
    addr_t base;
    addr_t lo;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    while (desc_seen < exp_addr.size()) step_cycle();
    for (p = 0; p < pkt_base.size(); p++) begin
      base = pkt_base[p];
      lo = base & ~addr_t'(BYTES_PER_WORD - 1);
      words = (int'(base[OFS_BITS-1:0]) + pkt_len[p] + BYTES_PER_WORD - 1) / BYTES_PER_WORD;
      check_region(lo - 16'd1, words * BYTES_PER_WORD + 2);
    end
    errs = total_errors() - test_err_base;
    tests_run++;
    if (errs == 0) begin
      $display("PASS %s", cur_test);
    end else begin
      tests_failed++;
      $display("FAIL %s with %0d errors", cur_test, errs);
    end
  endtask

  initial begin
    rst = 1'b1;
    s_axis_tdata = '0;
    s_axis_tkeep = '0;
    s_axis_tvalid = 1'b0;
    s_axis_tlast = 1'b0;
    s_axis_tdest = '0;
    s_axis_tuser = '0;
    wr_base_addr = '0;
    recv_desc_ready = 1'b1;
    ready_random = 1'b0;
    pay_state = LCG_SEED;
    repeat (2) @(posedge clk);
    #2;
    rst = 1'b0;
    step_cycle();

    start_test("aligned");
    send_packet(16'h0100, 24, 8'h11, 2'd1);
    end_test();

    // 5 + 20 bytes reach into a fourth word
    start_test("unaligned");
    send_packet(16'h0205, 20, 8'h22, 2'd2);
    end_test();

    start_test("partial_keep");
    send_packet(16'h0302, 17 + int'(lcg_next(pay_state) % 7), 8'h33, 2'd3);
    send_packet(16'h0347, 11, 8'h34, 2'd0);
    end_test();

    start_test("random_ready");
    ready_random = 1'b1;
    send_packet(16'h0403, 37, 8'h44, 2'd1);
    send_packet(16'h0481, 50, 8'h45, 2'd2);
    end_test();
    ready_random = 1'b0;

    // The short second packet closes while the first descriptor waits
    // Its descriptor is parked and the third packet stalls on its last beat
    start_test("held_descriptor");
    recv_desc_ready = 1'b0;
    fork
      begin
        send_packet(16'h0500, 16, 8'h55, 2'd3);
        send_packet(16'h0536, 5, 8'h57, 2'd1);
        send_packet(16'h0556, 21, 8'h56, 2'd0);
      end
      begin
        repeat (12) step_cycle();
        recv_desc_ready = 1'b1;
      end
    join
    end_test();

    start_test("back_to_back");
    send_packet(16'h0600, 13, 8'h66, 2'd1);
    send_packet(16'h0645, 30, 8'h67, 2'd2);
    send_packet(16'h06a1, 8, 8'h68, 2'd3);
    end_test();

    $display("Tests run %0d, failed %0d, check errors %0d, assertion failures %0d",
             tests_run, tests_failed, chk_errors + mon_errors, dut.sva.fail_count);
    if (tests_failed == 0 && total_errors() == 0) begin
      $display("Everything OK");
    end else begin
      $display("Something failed");
    end
    $finish;
  end

endmodule

// File: compile.f
logic/dma_wr_pkg.sv
logic/wr_capture.sv
logic/wr_align.sv
logic/wr_len_count.sv
logic/axis_wr_dma.sv
tests/axis_wr_dma_sva.sv
tests/tb_axis_wr_dma.sv

// File: run_sim.sh
#!/bin/sh
# Builds the write DMA testbench with Verilator and runs it

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert \
  -f compile.f \
  --top-module tb_axis_wr_dma \
  -o sim_axis_wr_dma
status=$?
if [ "$status" -ne 0 ]; then
  echo "Verilator build failed with status $status"
  exit 1
fi

# A high error limit lets the testbench reach its own verdict
output=$(./obj_dir/sim_axis_wr_dma +verilator+error+limit+1000)
status=$?
echo "$output"
if [ "$status" -ne 0 ]; then
  echo "Simulation exited with status $status"
  exit 1
fi

if echo "$output" | grep -qx "Everything OK"; then
  exit 0
fi
echo "Pass message not found in simulation output"
exit 1
